// File: common/msg_pkg.sv
package msg_pkg;

	// message field widths
	localparam int DATA_W = 8;
	localparam int RED_W  = 4;
	localparam int SRC_W  = 1;

	// counting range of both sources
	localparam logic [DATA_W-1:0] MIN_VAL = 8'd0;
	localparam logic [DATA_W-1:0] MAX_VAL = 8'd55;

	// short stability window, sized for simulation
	localparam int DEBOUNCE_LIMIT = 8;
	localparam int HEARTBEAT_MSGS = 16;

	typedef struct packed {
		logic [SRC_W-1:0]  src;
		logic [DATA_W-1:0] data;
		logic [RED_W-1:0]  red;
	} msg_t;

	// 4 bits wide so the code fills the lower display nibble directly
	typedef enum logic [3:0] {
		ERR_NONE  = 4'd0,
		ERR_REDUN = 4'd1,
		ERR_SEQ   = 4'd2
	} err_code_t;

	typedef enum logic {
		PRI_0 = 1'b0,
		PRI_1 = 1'b1
	} arb_state_t;

	// inverted xor of the two data nibbles
	function automatic logic [RED_W-1:0] redundancy(input logic [DATA_W-1:0] data);
		return ~(data[7:4] ^ data[3:0]);
	endfunction

	// next value of the counting sequence, wraps at the top of the range
	function automatic logic [DATA_W-1:0] next_val(input logic [DATA_W-1:0] val);
		if (val >= MAX_VAL) begin
			return MIN_VAL;
		end
		return val + 1'b1;
	endfunction

endpackage

// File: hdl/debounce.sv
`timescale 1ns/1ps

module debounce (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_switch,
	output logic o_switch
);

	logic                                      r_sync;
	logic [$clog2(msg_pkg::DEBOUNCE_LIMIT)-1:0] r_count;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_sync   <= 1'b0;
			r_count  <= '0;
			o_switch <= 1'b0;
		end else begin
			r_sync <= i_switch;
			// count only while the new level holds
			if (r_sync == o_switch) begin
				r_count <= '0;
			end else if (int'(r_count) == msg_pkg::DEBOUNCE_LIMIT - 1) begin
				o_switch <= r_sync;
				r_count  <= '0;
			end else begin
				r_count <= r_count + 1'b1;
			end
		end
	end

endmodule

// File: hdl/seg7_decoder.sv
`timescale 1ns/1ps

// segments packed as {A, B, C, D, E, F, G}, 1 lights a segment
module seg7_decoder (
	input  logic [3:0] i_nibble,
	output logic [6:0] o_segments
);

	always_comb begin
		case (i_nibble)
			4'h0: o_segments = 7'b1111110;
			4'h1: o_segments = 7'b0110000;
			4'h2: o_segments = 7'b1101101;
			4'h3: o_segments = 7'b1111001;
			4'h4: o_segments = 7'b0110011;
			4'h5: o_segments = 7'b1011011;
			4'h6: o_segments = 7'b1011111;
			4'h7: o_segments = 7'b1110000;
			4'h8: o_segments = 7'b1111111;
			4'h9: o_segments = 7'b1111011;
			4'ha: o_segments = 7'b1110111;
			4'hb: o_segments = 7'b0011111;
			4'hc: o_segments = 7'b1001110;
			4'hd: o_segments = 7'b0111101;
			4'he: o_segments = 7'b1001111;
			default: o_segments = 7'b1000111;
		endcase
	end

endmodule

// File: link_tester/msg_source.sv
`timescale 1ns/1ps

module msg_source (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic [msg_pkg::SRC_W-1:0] i_src_id,
	input  logic                      i_inject,
	output msg_pkg::msg_t             o_msg,
	output logic                      o_valid,
	input  logic                      i_ready
);

	logic [msg_pkg::DATA_W-1:0] r_data;
	logic                       r_valid;
	logic                       r_corrupt;
	logic                       r_injected;
	logic                       xfer;

	assign xfer = r_valid && i_ready;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_valid    <= 1'b0;
			r_data     <= msg_pkg::MIN_VAL;
			r_corrupt  <= 1'b0;
			r_injected <= 1'b0;
		end else begin
			r_valid <= 1'b1;
			// next message only after the current one is taken
			if (xfer) begin
				r_data    <= msg_pkg::next_val(r_data);
				r_corrupt <= i_inject && !r_injected;
				if (i_inject && !r_injected) begin
					r_injected <= 1'b1;
				end
			end
			// disarm once the request goes away
			if (!i_inject) begin
				r_injected <= 1'b0;
			end
		end
	end

	// fields only change on a transfer, so the message holds while stalled
	always_comb begin
		o_msg.src  = i_src_id;
		o_msg.data = r_data;
		o_msg.red  = msg_pkg::redundancy(r_data) ^ {msg_pkg::RED_W{r_corrupt}};
	end

	assign o_valid = r_valid;

endmodule

// File: link_tester/msg_checker.sv
`timescale 1ns/1ps

module msg_checker (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  msg_pkg::msg_t              i_msg,
	input  logic                       i_valid,
	output logic                       o_ready,
	output logic                       o_err,
	output logic [7:0]                 o_err_info,
	output logic [msg_pkg::DATA_W-1:0] o_last_data,
	output logic                       o_heartbeat
);

	logic [msg_pkg::DATA_W-1:0]                r_expect [2**msg_pkg::SRC_W];
	logic [$clog2(msg_pkg::HEARTBEAT_MSGS)-1:0] r_hb_count;
	msg_pkg::err_code_t                        code;

	// sink never stalls the link
	assign o_ready = 1'b1;

	// redundancy is checked before sequence
	always_comb begin
		code = msg_pkg::ERR_NONE;
		if (i_msg.red != msg_pkg::redundancy(i_msg.data)) begin
			code = msg_pkg::ERR_REDUN;
		end else if (i_msg.data != r_expect[i_msg.src]) begin
			code = msg_pkg::ERR_SEQ;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < 2**msg_pkg::SRC_W; i++) begin
				r_expect[i] <= msg_pkg::MIN_VAL;
			end
			o_err       <= 1'b0;
			o_err_info  <= 8'd0;
			o_last_data <= '0;
			o_heartbeat <= 1'b0;
			r_hb_count  <= '0;
		end else if (i_valid) begin
			// resync on the received value
			r_expect[i_msg.src] <= msg_pkg::next_val(i_msg.data);
			o_last_data         <= i_msg.data;
			// only the first error is kept
			if (!o_err && (code != msg_pkg::ERR_NONE)) begin
				o_err      <= 1'b1;
				o_err_info <= {{(4 - msg_pkg::SRC_W){1'b0}}, i_msg.src, code};
			end
			if (int'(r_hb_count) == msg_pkg::HEARTBEAT_MSGS - 1) begin
				r_hb_count  <= '0;
				o_heartbeat <= !o_heartbeat;
			end else begin
				r_hb_count <= r_hb_count + 1'b1;
			end
		end
	end

endmodule

// File: merge_node/merge_node.sv
`timescale 1ns/1ps

module merge_node (
	input  logic            i_clk,
	input  logic            i_rst,
	input  msg_pkg::msg_t   i_msg_0,
	input  logic            i_valid_0,
	output logic            o_ready_0,
	input  msg_pkg::msg_t   i_msg_1,
	input  logic            i_valid_1,
	output logic            o_ready_1,
	output msg_pkg::msg_t   o_msg,
	output logic            o_valid,
	input  logic            i_ready
);

	msg_pkg::msg_t      r_msg;
	logic               r_valid;
	msg_pkg::arb_state_t r_pri;

	logic can_accept;
	logic gnt_0;
	logic gnt_1;
	logic take_0;
	logic take_1;

	// buffer free, or its message leaves on this edge
	assign can_accept = !r_valid || i_ready;

	// on contention the input not served last wins
	assign gnt_0 = i_valid_0 && (!i_valid_1 || (r_pri == msg_pkg::PRI_0));
	assign gnt_1 = i_valid_1 && (!i_valid_0 || (r_pri == msg_pkg::PRI_1));

	assign o_ready_0 = can_accept && !gnt_1;
	assign o_ready_1 = can_accept && !gnt_0;

	assign take_0 = i_valid_0 && o_ready_0;
	assign take_1 = i_valid_1 && o_ready_1;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_valid <= 1'b0;
			r_pri   <= msg_pkg::PRI_0;
		end else begin
			if (take_0 || take_1) begin
				r_valid <= 1'b1;
			end else if (i_ready) begin
				r_valid <= 1'b0;
			end
			// hand priority to the other side after each grant
			if (take_0) begin
				r_pri <= msg_pkg::PRI_1;
			end else if (take_1) begin
				r_pri <= msg_pkg::PRI_0;
			end
		end
	end

	// message register, no reset needed
	always_ff @(posedge i_clk) begin
		if (take_0) begin
			r_msg <= i_msg_0;
		end else if (take_1) begin
			r_msg <= i_msg_1;
		end
	end

	assign o_msg   = r_msg;
	assign o_valid = r_valid;

endmodule

// File: hdl/link_test_top.sv
`timescale 1ns/1ps

module link_test_top (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_switch_1,
	input  logic       i_switch_2,
	output logic [6:0] o_segment_1,
	output logic [6:0] o_segment_2,
	output logic       o_led_1,
	output logic       o_led_2,
	output logic       o_led_3,
	output logic       o_led_4
);

	msg_pkg::msg_t              lnk_0_msg, lnk_1_msg, lnk_2_msg;
	logic                       lnk_0_valid, lnk_1_valid, lnk_2_valid;
	logic                       lnk_0_ready, lnk_1_ready, lnk_2_ready;
	logic                       err;
	logic [7:0]                 err_info;
	logic [msg_pkg::DATA_W-1:0] last_data;
	logic                       heartbeat;
	logic                       sw_1, sw_2, r_sw_1, r_sw_2;
	logic                       r_fault_armed;
	logic [7:0]                 disp_val;
	logic [6:0]                 seg_hi, seg_lo;

	msg_source src_0_i (.i_clk, .i_rst, .i_src_id(1'b0), .i_inject(1'b0),
		.o_msg(lnk_0_msg), .o_valid(lnk_0_valid), .i_ready(lnk_0_ready));
	// only source 1 takes fault injection
	msg_source src_1_i (.i_clk, .i_rst, .i_src_id(1'b1), .i_inject(r_fault_armed),
		.o_msg(lnk_1_msg), .o_valid(lnk_1_valid), .i_ready(lnk_1_ready));

	merge_node merge_node_i (.i_clk, .i_rst,
		.i_msg_0(lnk_0_msg), .i_valid_0(lnk_0_valid), .o_ready_0(lnk_0_ready),
		.i_msg_1(lnk_1_msg), .i_valid_1(lnk_1_valid), .o_ready_1(lnk_1_ready),
		.o_msg(lnk_2_msg), .o_valid(lnk_2_valid), .i_ready(lnk_2_ready));

	msg_checker checker_i (.i_clk, .i_rst, .i_msg(lnk_2_msg), .i_valid(lnk_2_valid),
		.o_ready(lnk_2_ready), .o_err(err), .o_err_info(err_info),
		.o_last_data(last_data), .o_heartbeat(heartbeat));

	debounce sw_1_i (.i_clk, .i_rst, .i_switch(i_switch_1), .o_switch(sw_1));
	debounce sw_2_i (.i_clk, .i_rst, .i_switch(i_switch_2), .o_switch(sw_2));

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_sw_1        <= 1'b0;
			r_sw_2        <= 1'b0;
			r_fault_armed <= 1'b0;
			disp_val      <= 8'd0;
		end else begin
			r_sw_1 <= sw_1;
			r_sw_2 <= sw_2;
			// show the first error if there is one, else the last checked data
			if (sw_1 && !r_sw_1) begin
				disp_val <= err ? err_info : last_data;
			end
			// disarm once a corrupted message from source 1 has left
			if (sw_2 && !r_sw_2) begin
				r_fault_armed <= 1'b1;
			end else if (lnk_1_valid && lnk_1_ready &&
					(lnk_1_msg.red != msg_pkg::redundancy(lnk_1_msg.data))) begin
				r_fault_armed <= 1'b0;
			end
		end
	end

	seg7_decoder seg_hi_i (.i_nibble(disp_val[7:4]), .o_segments(seg_hi));
	seg7_decoder seg_lo_i (.i_nibble(disp_val[3:0]), .o_segments(seg_lo));

	// board segments are active low
	assign o_segment_1 = ~seg_hi;
	assign o_segment_2 = ~seg_lo;

	assign o_led_1 = err;
	assign o_led_2 = r_fault_armed;
	assign o_led_3 = err && (err_info[3:0] == msg_pkg::ERR_SEQ);
	assign o_led_4 = heartbeat;

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk
);

	// 100 ns period
	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

endmodule

// File: testbench/link_test_assertions.sv
`timescale 1ns/1ps

module link_test_assertions (
	input logic          i_clk,
	input logic          i_rst,
	input msg_pkg::msg_t i_msg,
	input logic          i_valid,
	input logic          i_ready,
	input logic          i_err,
	input logic [3:0]    i_leds
);

	// source 1 holds its message while the merge node stalls it
	assert property (@(posedge i_clk) disable iff (i_rst)
		i_valid && !i_ready |=> i_valid && $stable(i_msg))
		else $error("stalled message on link 1 changed before ready");

	// first error stays latched
	assert property (@(posedge i_clk) disable iff (i_rst) i_err |=> i_err)
		else $error("checker error flag fell without reset");

	assert property (@(posedge i_clk) $fell(i_rst) |-> i_leds == 4'b0)
		else $error("LEDs not clear in the cycle after reset");

endmodule

// link 1 into the merge node is stalled whenever source 0 wins arbitration
bind link_test_top link_test_assertions assertions_i (
	.i_clk, .i_rst, .i_msg(lnk_1_msg), .i_valid(lnk_1_valid), .i_ready(lnk_1_ready),
	.i_err(err), .i_leds({o_led_1, o_led_2, o_led_3, o_led_4})
);

// File: testbench/tb_link_test.sv
`timescale 1ns/1ps

module tb_link_test;

	localparam int FIELDS     = 6;
	localparam int MAX_STEPS  = 32;
	localparam int SETTLE     = 2 * msg_pkg::DEBOUNCE_LIMIT + 4;
	localparam int WAIT_LIMIT = 100;
	// lit segments {A..G} of hex digits 0 to f
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
		7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47
	};

	logic        clk;
	logic        rst;
	logic        switch_1;
	logic        switch_2;
	logic [6:0]  segment_1;
	logic [6:0]  segment_2;
	logic        led_1, led_2, led_3, led_4, led_4_prev;
	logic [11:0] stim [FIELDS*MAX_STEPS];
	int          heartbeat_toggles;

	tb_clock_gen clock_gen_i (.o_clk(clk));

	link_test_top link_test_top_i (
		.i_clk(clk), .i_rst(rst), .i_switch_1(switch_1), .i_switch_2(switch_2),
		.o_segment_1(segment_1), .o_segment_2(segment_2),
		.o_led_1(led_1), .o_led_2(led_2), .o_led_3(led_3), .o_led_4(led_4)
	);

	always @(negedge clk) begin
		led_4_prev <= led_4;
		if (rst) begin
			heartbeat_toggles <= 0;
		end else if (led_4 != led_4_prev) begin
			heartbeat_toggles <= heartbeat_toggles + 1;
		end
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			stop_with_failure($sformatf("Mismatch %s expected %0h actual %0h", name, exp, act));
		end
	endtask

	// active-low segments back to {invalid, nibble}
	function automatic logic [4:0] decode_digit(input logic [6:0] seg_n);
		decode_digit = 5'h10;
		for (int n = 0; n < 16; n++) begin
			if (~seg_n == SEG_TABLE[n]) begin
				decode_digit = {1'b0, 4'(n)};
			end
		end
	endfunction

	task automatic check_display(input string name, input logic [11:0] mode,
			input logic [11:0] value);
		logic [4:0] hi;
		logic [4:0] lo;
		hi = decode_digit(segment_1);
		lo = decode_digit(segment_2);
		check({name, " upper digit decodes"}, 32'd0, 32'(hi[4]));
		check({name, " lower digit decodes"}, 32'd0, 32'(lo[4]));
		if (mode == 1) begin
			check({name, " value in range"}, 32'd1,
				32'({hi[3:0], lo[3:0]} <= msg_pkg::MAX_VAL));
		end else if (mode == 2) begin
			check({name, " display"}, 32'(value), 32'({hi[3:0], lo[3:0]}));
		end
	endtask

	task automatic run_step(input int s);
		logic [11:0] action;
		logic [11:0] exp_led_1;
		string       name;
		int          t;
		action    = stim[FIELDS*s];
		exp_led_1 = stim[FIELDS*s+2];
		name      = $sformatf("step %0d", s);
		@(posedge clk);
		switch_1 <= (action == 1);
		switch_2 <= (action == 2);
		repeat (stim[FIELDS*s+1]) @(posedge clk);
		switch_1 <= 1'b0;
		switch_2 <= 1'b0;
		// let the release pass the debounce
		repeat (SETTLE) @(posedge clk);
		@(negedge clk);
		t = 0;
		while (exp_led_1 != 0 && !led_1 && t < WAIT_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (exp_led_1 != 0 && !led_1) begin
			stop_with_failure({name, " timed out waiting for LED 1 to rise"});
		end
		check({name, " led 1"}, 32'(exp_led_1), 32'(led_1));
		check({name, " led 2"}, 32'd0, 32'(led_2));
		check({name, " led 3"}, 32'(stim[FIELDS*s+3]), 32'(led_3));
		check_display(name, stim[FIELDS*s+4], stim[FIELDS*s+5]);
	endtask

	initial begin
		rst      = 1'b1;
		switch_1 = 1'b0;
		switch_2 = 1'b0;
		$readmemh("testbench/link_test_stim.txt", stim);
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("reset leds", 32'd0, 32'({led_1, led_2, led_3, led_4}));
		for (int s = 0; s < MAX_STEPS && stim[FIELDS*s] != 12'hfff; s++) begin
			run_step(s);
		end
		check("heartbeat toggles", 32'd1, 32'(heartbeat_toggles > 0));
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: testbench/link_test_stim.txt
// action (0 idle, 1 switch 1, 2 switch 2, fff end) hold led_1 led_3
// display mode (0 none, 1 in range, 2 exact) display value, all hex
0 001 0 0 2 00 // reset state
1 014 0 0 1 00 // fault-free capture
0 0c8 0 0 1 00 // 200 cycles through the merge
2 014 1 0 0 00 // inject on source 1
1 014 1 0 2 11 // source 1, redundancy error
1 014 1 0 2 11
2 014 1 0 2 11 // second fault is not latched
1 014 1 0 2 11
fff 000 0 0 0 00

// File: filelist.f
common/msg_pkg.sv
hdl/debounce.sv
hdl/seg7_decoder.sv
link_tester/msg_source.sv
link_tester/msg_checker.sv
merge_node/merge_node.sv
hdl/link_test_top.sv
testbench/tb_clock_gen.sv
testbench/link_test_assertions.sv
testbench/tb_link_test.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_link_test
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
